// File: include/alu_exec_defines.svh
`ifndef ALU_EXEC_DEFINES_SVH
`define ALU_EXEC_DEFINES_SVH

// Datapath and instruction width
`define ALU_EXEC_WORD_W 16

// Register file geometry
`define ALU_EXEC_REG_AW 3
`define ALU_EXEC_NUM_REGS 8

// Data memory holds 2**MEM_AW words
`define ALU_EXEC_MEM_AW 4

// JAL and JALR write the return address here
`define ALU_EXEC_LINK_REG 7

`endif

// File: rtl/alu_exec_pkg.sv
`include "alu_exec_defines.svh"

package alu_exec_pkg;

	typedef logic [`ALU_EXEC_WORD_W-1:0] word_t;
	typedef logic [`ALU_EXEC_REG_AW-1:0] reg_addr_t;

	// Major opcode, instr[15:11]
	typedef enum logic [4:0] {
		OPC_HALT = 5'b00000, OPC_NOP   = 5'b00001, OPC_SIIC  = 5'b00010, OPC_RTI   = 5'b00011,
		OPC_J    = 5'b00100, OPC_JR    = 5'b00101, OPC_JAL   = 5'b00110, OPC_JALR  = 5'b00111,
		OPC_ADDI = 5'b01000, OPC_SUBI  = 5'b01001, OPC_ORI   = 5'b01010, OPC_ANDI  = 5'b01011,
		OPC_BEQZ = 5'b01100, OPC_BNEZ  = 5'b01101, OPC_RET   = 5'b01110, OPC_BLTZ  = 5'b01111,
		OPC_ST   = 5'b10000, OPC_LD    = 5'b10001, OPC_SLBI  = 5'b10010, OPC_STU   = 5'b10011,
		OPC_ROLI = 5'b10100, OPC_SLLI  = 5'b10101, OPC_RORI  = 5'b10110, OPC_SRAI  = 5'b10111,
		OPC_LBI  = 5'b11000, OPC_BTR   = 5'b11001, OPC_SHIFT = 5'b11010, OPC_ARITH = 5'b11011,
		OPC_SEQ  = 5'b11100, OPC_SLT   = 5'b11101, OPC_SLE   = 5'b11110, OPC_SCO   = 5'b11111
	} opcode_e;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB,                 // SUB is b minus a
		OP_OR, OP_AND,
		OP_ROL, OP_SLL, OP_ROR, OP_SRA,
		OP_SEQ, OP_SLT, OP_SLE, OP_SCO,
		OP_BTR,
		OP_PASS_B,
		OP_SLBI                         // (a << 8) | b
	} alu_op_e;

	typedef enum logic [2:0] {B_REG, B_SIMM5, B_ZIMM5, B_SIMM8, B_ZIMM8} src_b_e;

	typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} res_sel_e;

endpackage

// File: rtl/alu_destination_decode.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module alu_destination_decode (
	input  alu_exec_pkg::word_t     instr,
	output alu_exec_pkg::reg_addr_t rd,
	output logic                    we_reg
);
	import alu_exec_pkg::*;

	logic [6:0] op_key;
	opcode_e    opcode;
	reg_addr_t  rd_reg;
	reg_addr_t  rd_imm;
	reg_addr_t  rd_rs;

	assign op_key = {instr[15:11], instr[1:0]};
	assign opcode = opcode_e'(op_key[6:2]);

	assign rd_reg = instr[4:2];     // R-format Rd
	assign rd_imm = instr[7:5];     // I-format Rd
	assign rd_rs  = instr[10:8];    // Rs doubles as target

	always_comb begin
		rd     = rd_reg;            // Keeps rd defined on no-write ops
		we_reg = 1'b0;
		case (opcode)
			// Register groups, fn picks the operation but every variant writes Rd
			OPC_ARITH, OPC_SHIFT: begin
				we_reg = 1'b1;
			end
			OPC_SEQ, OPC_SLT, OPC_SLE, OPC_SCO: begin
				we_reg = 1'b1;
			end
			OPC_BTR: begin
				we_reg = 1'b1;
			end

			OPC_ADDI, OPC_SUBI, OPC_ORI, OPC_ANDI: begin
				rd     = rd_imm;
				we_reg = 1'b1;
			end
			OPC_ROLI, OPC_SLLI, OPC_RORI, OPC_SRAI: begin
				rd     = rd_imm;
				we_reg = 1'b1;
			end
			OPC_LD: begin
				rd     = rd_imm;
				we_reg = 1'b1;
			end

			OPC_LBI, OPC_SLBI: begin
				rd     = rd_rs;
				we_reg = 1'b1;
			end
			OPC_STU: begin       // Updated address back into Rs
				rd     = rd_rs;
				we_reg = 1'b1;
			end

			OPC_JAL, OPC_JALR: begin
				rd     = reg_addr_t'(`ALU_EXEC_LINK_REG);
				we_reg = 1'b1;
			end

			// ST, branches, J, JR, RET, SIIC, RTI, HALT, NOP
			default: begin
				we_reg = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/alu_control_decode.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module alu_control_decode (
	input  alu_exec_pkg::word_t    instr,
	output alu_exec_pkg::alu_op_e  alu_op,
	output alu_exec_pkg::src_b_e   src_b,
	output alu_exec_pkg::res_sel_e res_sel,
	output logic                   mem_we,
	output logic                   is_halt
);
	import alu_exec_pkg::*;

	logic [6:0] op_key;
	opcode_e    opcode;
	logic [1:0] fn;

	assign op_key = {instr[15:11], instr[1:0]};
	assign opcode = opcode_e'(op_key[6:2]);
	assign fn     = op_key[1:0];

	always_comb begin
		alu_op  = OP_PASS_B;
		src_b   = B_REG;
		res_sel = RES_ALU;
		mem_we  = 1'b0;
		is_halt = 1'b0;
		case (opcode)
			OPC_ARITH: begin
				case (fn)
					2'b00:   alu_op = OP_ADD;
					2'b01:   alu_op = OP_SUB;
					2'b10:   alu_op = OP_OR;
					default: alu_op = OP_AND;
				endcase
			end
			OPC_SHIFT: begin
				case (fn)
					2'b00:   alu_op = OP_ROL;
					2'b01:   alu_op = OP_SLL;
					2'b10:   alu_op = OP_ROR;
					default: alu_op = OP_SRA;
				endcase
			end
			OPC_SEQ: alu_op = OP_SEQ;
			OPC_SLT: alu_op = OP_SLT;
			OPC_SLE: alu_op = OP_SLE;
			OPC_SCO: alu_op = OP_SCO;
			OPC_BTR: alu_op = OP_BTR;

			OPC_ADDI: begin alu_op = OP_ADD; src_b = B_SIMM5; end
			OPC_SUBI: begin alu_op = OP_SUB; src_b = B_SIMM5; end
			OPC_ORI:  begin alu_op = OP_OR;  src_b = B_ZIMM5; end
			OPC_ANDI: begin alu_op = OP_AND; src_b = B_ZIMM5; end
			OPC_ROLI: begin alu_op = OP_ROL; src_b = B_ZIMM5; end
			OPC_SLLI: begin alu_op = OP_SLL; src_b = B_ZIMM5; end
			OPC_RORI: begin alu_op = OP_ROR; src_b = B_ZIMM5; end
			OPC_SRAI: begin alu_op = OP_SRA; src_b = B_ZIMM5; end

			OPC_LBI:  begin alu_op = OP_PASS_B; src_b = B_SIMM8; end
			OPC_SLBI: begin alu_op = OP_SLBI;   src_b = B_ZIMM8; end

			OPC_LD: begin            // Address is Rs + simm5
				alu_op  = OP_ADD;
				src_b   = B_SIMM5;
				res_sel = RES_MEM;
			end
			OPC_ST, OPC_STU: begin
				alu_op = OP_ADD;
				src_b  = B_SIMM5;
				mem_we = 1'b1;
			end

			OPC_JAL, OPC_JALR: res_sel = RES_LINK;
			OPC_HALT:          is_halt = 1'b1;
			default: ;               // Branches and jumps, nothing to do here
		endcase
	end

	// A store that also halted would leave memory changed after the stop
	always_comb begin
		assert (!(mem_we && is_halt))
			else $error("control decode: mem_we and is_halt both high");
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module register_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  alu_exec_pkg::reg_addr_t raddr_a,
	input  alu_exec_pkg::reg_addr_t raddr_b,
	output alu_exec_pkg::word_t     rdata_a,
	output alu_exec_pkg::word_t     rdata_b,
	input  logic                    we,
	input  alu_exec_pkg::reg_addr_t waddr,
	input  alu_exec_pkg::word_t     wdata
);
	import alu_exec_pkg::*;

	word_t regs [`ALU_EXEC_NUM_REGS];   // R0 is an ordinary register

	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ALU_EXEC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module alu (
	input  alu_exec_pkg::word_t   a,
	input  alu_exec_pkg::word_t   b_reg,
	input  alu_exec_pkg::word_t   instr,
	input  alu_exec_pkg::alu_op_e alu_op,
	input  alu_exec_pkg::src_b_e  src_b,
	output alu_exec_pkg::word_t   result
);
	import alu_exec_pkg::*;

	localparam int W = `ALU_EXEC_WORD_W;

	word_t        b;
	logic [3:0]   shamt;
	logic [W:0]   sum;
	logic [2*W-1:0] rol_full;
	logic [2*W-1:0] ror_full;
	word_t        a_rev;
	logic         lt;
	logic         eq;

	// Operand B
	always_comb begin
		case (src_b)
			B_SIMM5: b = {{(W-5){instr[4]}}, instr[4:0]};
			B_ZIMM5: b = {{(W-5){1'b0}}, instr[4:0]};
			B_SIMM8: b = {{(W-8){instr[7]}}, instr[7:0]};
			B_ZIMM8: b = {{(W-8){1'b0}}, instr[7:0]};
			default: b = b_reg;
		endcase
	end

	assign shamt    = b[3:0];
	assign sum      = {1'b0, a} + {1'b0, b};    // Top bit is the SCO carry
	assign rol_full = {a, a} << shamt;
	assign ror_full = {a, a} >> shamt;
	assign a_rev    = {<<{a}};
	assign lt       = $signed(a) < $signed(b);
	assign eq       = (a == b);

	always_comb begin
		case (alu_op)
			OP_ADD:  result = sum[W-1:0];
			OP_SUB:  result = b - a;
			OP_OR:   result = a | b;
			OP_AND:  result = a & b;
			OP_ROL:  result = rol_full[2*W-1:W];
			OP_SLL:  result = a << shamt;
			OP_ROR:  result = ror_full[W-1:0];
			OP_SRA:  result = word_t'($signed(a) >>> shamt);
			OP_SEQ:  result = word_t'(eq);
			OP_SLT:  result = word_t'(lt);
			OP_SLE:  result = word_t'(lt || eq);
			OP_SCO:  result = word_t'(sum[W]);
			OP_BTR:  result = a_rev;
			OP_SLBI: result = (a << 8) | b;
			default: result = b;        // PASS_B, used by LBI
		endcase
	end

endmodule

// File: rtl/data_memory.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module data_memory (
	input  logic                clk,
	input  logic                rst_n,
	input  alu_exec_pkg::word_t addr,
	output alu_exec_pkg::word_t rdata,
	input  logic                we,
	input  alu_exec_pkg::word_t wdata
);
	import alu_exec_pkg::*;

	localparam int DEPTH = 1 << `ALU_EXEC_MEM_AW;

	word_t mem [DEPTH];
	logic [`ALU_EXEC_MEM_AW-1:0] word_addr;

	assign word_addr = addr[`ALU_EXEC_MEM_AW:1];    // Byte address to word index
	assign rdata     = mem[word_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[word_addr] <= wdata;
		end
	end

	// Words are 2-byte aligned, bit 0 is silently dropped
	assert property (@(posedge clk) disable iff (!rst_n) we |-> !addr[0])
		else $error("data memory: write to odd address %h", addr);

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module writeback_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  logic                    we_reg,
	input  logic                    mem_we_dec,
	input  logic                    is_halt,
	input  alu_exec_pkg::reg_addr_t rd,
	input  alu_exec_pkg::res_sel_e  res_sel,
	input  alu_exec_pkg::word_t     alu_result,
	input  alu_exec_pkg::word_t     mem_rdata,
	input  alu_exec_pkg::word_t     pc,
	output logic                    reg_we,
	output logic                    mem_we,
	output alu_exec_pkg::word_t     wb_data_next,
	output logic                    wb_valid,
	output logic                    wb_we,
	output alu_exec_pkg::reg_addr_t wb_rd,
	output alu_exec_pkg::word_t     wb_data,
	output logic                    halted
);
	import alu_exec_pkg::*;

	logic commit;

	assign commit = instr_valid && !halted;     // Nothing retires once halted
	assign reg_we = commit && we_reg;
	assign mem_we = commit && mem_we_dec;

	always_comb begin
		case (res_sel)
			RES_MEM:  wb_data_next = mem_rdata;
			RES_LINK: wb_data_next = pc + word_t'(2);   // Return address
			default:  wb_data_next = alu_result;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_valid <= commit;
			wb_we    <= reg_we;
			if (commit && is_halt) begin
				halted <= 1'b1;         // Sticky until reset
			end
		end
	end

	// Payload only, qualified by wb_valid
	always_ff @(posedge clk) begin
		if (commit) begin
			wb_rd   <= rd;
			wb_data <= wb_data_next;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> wb_valid)
		else $error("writeback: wb_we without wb_valid");

	// HALT itself is reported as a commit without a register write
	assert property (@(posedge clk) disable iff (!rst_n) $rose(halted) |-> wb_valid && !wb_we)
		else $error("writeback: halt latched without its own commit");

endmodule

// File: rtl/alu_exec_unit.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module alu_exec_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  alu_exec_pkg::word_t     instr,
	input  alu_exec_pkg::word_t     pc,
	output logic                    wb_valid,
	output logic                    wb_we,
	output alu_exec_pkg::reg_addr_t wb_rd,
	output alu_exec_pkg::word_t     wb_data,
	output logic                    halted
);
	import alu_exec_pkg::*;

	reg_addr_t rd;
	logic      we_reg;
	alu_op_e   alu_op;
	src_b_e    src_b;
	res_sel_e  res_sel;
	logic      mem_we_dec;
	logic      is_halt;
	word_t     rdata_a;
	word_t     rdata_b;
	word_t     alu_result;
	word_t     mem_rdata;
	word_t     wb_data_next;
	logic      reg_we;
	logic      mem_we;

	alu_destination_decode dest_dec_i (
		.instr  (instr),
		.rd     (rd),
		.we_reg (we_reg)
	);

	alu_control_decode ctrl_dec_i (
		.instr   (instr),
		.alu_op  (alu_op),
		.src_b   (src_b),
		.res_sel (res_sel),
		.mem_we  (mem_we_dec),
		.is_halt (is_halt)
	);

	register_file regfile_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_a (instr[10:8]),     // Rs
		.raddr_b (instr[7:5]),      // Rt or store data
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.we      (reg_we),
		.waddr   (rd),
		.wdata   (wb_data_next)
	);

	alu alu_i (
		.a      (rdata_a),
		.b_reg  (rdata_b),
		.instr  (instr),
		.alu_op (alu_op),
		.src_b  (src_b),
		.result (alu_result)
	);

	data_memory dmem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (alu_result),
		.rdata (mem_rdata),
		.we    (mem_we),
		.wdata (rdata_b)
	);

	writeback_stage wb_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.we_reg       (we_reg),
		.mem_we_dec   (mem_we_dec),
		.is_halt      (is_halt),
		.rd           (rd),
		.res_sel      (res_sel),
		.alu_result   (alu_result),
		.mem_rdata    (mem_rdata),
		.pc           (pc),
		.reg_we       (reg_we),
		.mem_we       (mem_we),
		.wb_data_next (wb_data_next),
		.wb_valid     (wb_valid),
		.wb_we        (wb_we),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.halted       (halted)
	);

endmodule

// File: tests/alu_exec_unit_tb.sv
`timescale 1ns/10ps
`include "alu_exec_defines.svh"

module alu_exec_unit_tb;
	import alu_exec_pkg::*;

	localparam int WAIT_LIMIT = 20;     // Cycles before a wait gives up
	localparam int RAND_COUNT = 40;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	word_t     instr;
	word_t     pc;
	logic      wb_valid;
	logic      wb_we;
	reg_addr_t wb_rd;
	word_t     wb_data;
	logic      halted;

	word_t     tbl_instr[$];
	word_t     tbl_pc[$];
	logic      tbl_we[$];
	reg_addr_t tbl_rd[$];
	word_t     tbl_data[$];
	string     tbl_name[$];

	word_t       model_regs [`ALU_EXEC_NUM_REGS];
	logic [31:0] lfsr_state;
	int          error_count;
	int          test_count;
	int          failed_tests;

	alu_exec_unit dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_we       (wb_we),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.halted      (halted)
	);

	always #20 clk = ~clk;

	function automatic word_t enc_r(logic [4:0] opc, reg_addr_t rs, reg_addr_t rt,
			reg_addr_t rd, logic [1:0] fn);
		return {opc, rs, rt, rd, fn};
	endfunction

	function automatic word_t enc_i(logic [4:0] opc, reg_addr_t rs, reg_addr_t rd,
			logic [4:0] imm);
		return {opc, rs, rd, imm};
	endfunction

	function automatic word_t enc_b(logic [4:0] opc, reg_addr_t rs, logic [7:0] imm);
		return {opc, rs, imm};
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [15:0] take_bits(int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[14:0], fb};
		end
		return v;
	endfunction

	// Kind 0 ADD, 1 SUB as b minus a, 2 signed SLT, 3 carry of a plus b
	function automatic word_t ref_result(logic [1:0] kind, word_t a, word_t b);
		word_t total;
		total = a + b;
		case (kind)
			2'd0:    return total;
			2'd1:    return b - a;
			2'd2:    return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
			default: return (total < a) ? word_t'(1) : word_t'(0);    // Sum wrapped around
		endcase
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_rd(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic add_row(word_t i_word, word_t i_pc, logic we, reg_addr_t rd, word_t data,
			string name);
		tbl_instr.push_back(i_word);
		tbl_pc.push_back(i_pc);
		tbl_we.push_back(we);
		tbl_rd.push_back(rd);
		tbl_data.push_back(data);
		tbl_name.push_back(name);
	endtask

	task automatic apply_reset();
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// One-cycle strobe, returns just after the committing edge
	task automatic issue(word_t i_word, word_t i_pc);
		@(posedge clk);
		#2;
		instr_valid = 1'b1;
		instr       = i_word;
		pc          = i_pc;
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	task automatic wait_valid(output logic seen);
		int cycles;
		cycles = 0;
		while (!wb_valid && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		seen = wb_valid;
	endtask

	task automatic end_test(string name, int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("%-14s pass", name);
		end else begin
			failed_tests++;
			$display("%-14s fail", name);
		end
	endtask

	task automatic build_table();
		add_row(enc_b(OPC_LBI, 3'd1, 8'h35), 16'h0040, 1'b1, 3'd1, 16'h0035, "lbi_r1");
		add_row(enc_b(OPC_LBI, 3'd2, 8'hfd), 16'h0040, 1'b1, 3'd2, 16'hfffd, "lbi_r2_neg");
		add_row(enc_b(OPC_LBI, 3'd3, 8'h04), 16'h0040, 1'b1, 3'd3, 16'h0004, "lbi_r3");
		add_row(enc_r(OPC_ARITH, 3'd1, 3'd2, 3'd4, 2'b00), 16'h0040, 1'b1, 3'd4, 16'h0032, "add");
		add_row(enc_r(OPC_ARITH, 3'd1, 3'd2, 3'd4, 2'b01), 16'h0040, 1'b1, 3'd4, 16'hffc8, "sub");
		add_row(enc_r(OPC_ARITH, 3'd1, 3'd2, 3'd4, 2'b10), 16'h0040, 1'b1, 3'd4, 16'hfffd, "or");
		add_row(enc_r(OPC_ARITH, 3'd1, 3'd2, 3'd4, 2'b11), 16'h0040, 1'b1, 3'd4, 16'h0035, "and");
		add_row(enc_r(OPC_SHIFT, 3'd2, 3'd3, 3'd5, 2'b00), 16'h0040, 1'b1, 3'd5, 16'hffdf, "rol");
		add_row(enc_r(OPC_SHIFT, 3'd1, 3'd3, 3'd5, 2'b01), 16'h0040, 1'b1, 3'd5, 16'h0350, "sll");
		add_row(enc_r(OPC_SHIFT, 3'd1, 3'd3, 3'd5, 2'b10), 16'h0040, 1'b1, 3'd5, 16'h5003, "ror");
		add_row(enc_r(OPC_SHIFT, 3'd2, 3'd3, 3'd5, 2'b11), 16'h0040, 1'b1, 3'd5, 16'hffff, "sra");
		add_row(enc_r(OPC_SEQ, 3'd1, 3'd1, 3'd6, 2'b00), 16'h0040, 1'b1, 3'd6, 16'h0001, "seq");
		add_row(enc_r(OPC_SLT, 3'd2, 3'd1, 3'd6, 2'b00), 16'h0040, 1'b1, 3'd6, 16'h0001, "slt");
		add_row(enc_r(OPC_SLE, 3'd1, 3'd2, 3'd6, 2'b00), 16'h0040, 1'b1, 3'd6, 16'h0000, "sle");
		add_row(enc_r(OPC_SCO, 3'd1, 3'd2, 3'd6, 2'b00), 16'h0040, 1'b1, 3'd6, 16'h0001, "sco");
		add_row(enc_r(OPC_BTR, 3'd1, 3'd0, 3'd6, 2'b00), 16'h0040, 1'b1, 3'd6, 16'hac00, "btr");
		add_row(enc_i(OPC_ADDI, 3'd1, 3'd4, 5'h1e), 16'h0040, 1'b1, 3'd4, 16'h0033, "addi");
		add_row(enc_i(OPC_SUBI, 3'd1, 3'd4, 5'h01), 16'h0040, 1'b1, 3'd4, 16'hffcc, "subi");
		add_row(enc_i(OPC_ORI, 3'd1, 3'd4, 5'h18), 16'h0040, 1'b1, 3'd4, 16'h003d, "ori");
		add_row(enc_i(OPC_ANDI, 3'd2, 3'd4, 5'h1c), 16'h0040, 1'b1, 3'd4, 16'h001c, "andi");
		add_row(enc_i(OPC_ROLI, 3'd1, 3'd5, 5'h08), 16'h0040, 1'b1, 3'd5, 16'h3500, "roli");
		add_row(enc_i(OPC_SLLI, 3'd1, 3'd5, 5'h0c), 16'h0040, 1'b1, 3'd5, 16'h5000, "slli");
		add_row(enc_i(OPC_RORI, 3'd1, 3'd5, 5'h01), 16'h0040, 1'b1, 3'd5, 16'h801a, "rori");
		add_row(enc_i(OPC_SRAI, 3'd2, 3'd5, 5'h01), 16'h0040, 1'b1, 3'd5, 16'hfffe, "srai");
		add_row(enc_b(OPC_SLBI, 3'd3, 8'ha7), 16'h0040, 1'b1, 3'd3, 16'h04a7, "slbi");
		add_row(enc_b(OPC_LBI, 3'd0, 8'h10), 16'h0040, 1'b1, 3'd0, 16'h0010, "lbi_base");
		add_row(enc_i(OPC_ST, 3'd0, 3'd2, 5'h06), 16'h0040, 1'b0, 3'd0, 16'h0000, "st");
		add_row(enc_i(OPC_LD, 3'd0, 3'd4, 5'h06), 16'h0040, 1'b1, 3'd4, 16'hfffd, "ld");
		add_row(enc_b(OPC_LBI, 3'd5, 8'h1a), 16'h0040, 1'b1, 3'd5, 16'h001a, "lbi_r5");
		add_row(enc_i(OPC_LD, 3'd5, 3'd4, 5'h1c), 16'h0040, 1'b1, 3'd4, 16'hfffd, "ld_neg_off");
		add_row(enc_i(OPC_STU, 3'd0, 3'd6, 5'h1e), 16'h0040, 1'b1, 3'd0, 16'h000e, "stu");
		add_row(enc_i(OPC_LD, 3'd0, 3'd4, 5'h00), 16'h0040, 1'b1, 3'd4, 16'hac00, "ld_after_stu");
		add_row(enc_b(OPC_JAL, 3'd0, 8'h00), 16'h0120, 1'b1, 3'd7, 16'h0122, "jal");
		add_row(enc_b(OPC_JALR, 3'd2, 8'h04), 16'h0ffe, 1'b1, 3'd7, 16'h1000, "jalr");
		add_row(enc_i(OPC_ORI, 3'd7, 3'd4, 5'h00), 16'h0040, 1'b1, 3'd4, 16'h1000, "link_read");
		add_row(enc_b(OPC_BEQZ, 3'd1, 8'h08), 16'h0040, 1'b0, 3'd0, 16'h0000, "beqz");
		add_row(enc_b(OPC_J, 3'd0, 8'h10), 16'h0040, 1'b0, 3'd0, 16'h0000, "j");
		add_row(enc_b(OPC_NOP, 3'd0, 8'h00), 16'h0040, 1'b0, 3'd0, 16'h0000, "nop");
	endtask

	task automatic run_table();
		logic seen;
		int   errs;
		for (int r = 0; r < tbl_instr.size(); r++) begin
			errs = error_count;
			issue(tbl_instr[r], tbl_pc[r]);
			wait_valid(seen);
			if (!seen) begin
				$display("%s: no wb_valid within %0d cycles", tbl_name[r], WAIT_LIMIT);
				error_count++;
			end else begin
				check_bit("wb_we", wb_we, tbl_we[r]);
				if (tbl_we[r]) begin          // Payload only matters on a write
					check_rd("wb_rd", wb_rd, tbl_rd[r]);
					check_word("wb_data", wb_data, tbl_data[r]);
				end
			end
			end_test(tbl_name[r], errs);
		end
	endtask

	task automatic run_halt();
		logic seen;
		int   errs;
		errs = error_count;
		issue(enc_b(OPC_HALT, 3'd0, 8'h00), 16'h0040);
		wait_valid(seen);
		if (!seen) begin
			$display("halt: no wb_valid within %0d cycles", WAIT_LIMIT);
			error_count++;
		end else begin
			check_bit("wb_we", wb_we, 1'b0);
		end
		check_bit("halted", halted, 1'b1);
		issue(enc_b(OPC_LBI, 3'd1, 8'h44), 16'h0040);
		wait_valid(seen);                 // Expected to run out
		if (seen) begin
			$display("halt: wb_valid rose for a strobe after HALT");
			error_count++;
		end
		apply_reset();
		check_bit("halted", halted, 1'b0);
		issue(enc_i(OPC_ORI, 3'd1, 3'd4, 5'h00), 16'h0040);    // R1 was 0x0035
		wait_valid(seen);
		if (!seen) begin
			$display("halt: no wb_valid for the read back after reset");
			error_count++;
		end else begin
			check_word("wb_data", wb_data, 16'h0000);
		end
		end_test("halt", errs);
	endtask

	// Back to back strobes, each result checked one cycle later
	task automatic run_random();
		logic       pend;
		reg_addr_t  pend_rd;
		word_t      pend_data;
		logic [2:0] kind;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [7:0] imm;
		int         errs;
		errs      = error_count;
		pend      = 1'b0;
		pend_rd   = '0;
		pend_data = '0;
		for (int r = 0; r < `ALU_EXEC_NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		for (int n = 0; n <= RAND_COUNT; n++) begin
			@(posedge clk);
			#2;
			if (pend) begin
				check_bit("wb_valid", wb_valid, 1'b1);
				check_bit("wb_we", wb_we, 1'b1);
				check_rd("wb_rd", wb_rd, pend_rd);
				check_word("wb_data", wb_data, pend_data);
			end
			pend        = (n < RAND_COUNT);
			instr_valid = pend;
			if (pend) begin
				kind = 3'(take_bits(3));
				rs   = reg_addr_t'(take_bits(3));
				rt   = reg_addr_t'(take_bits(3));
				rd   = reg_addr_t'(take_bits(3));
				if (kind[2]) begin
					imm       = 8'(take_bits(8));
					instr     = enc_b(OPC_LBI, rs, imm);
					pend_rd   = rs;
					pend_data = {{8{imm[7]}}, imm};
				end else begin
					case (kind[1:0])
						2'd0:    instr = enc_r(OPC_ARITH, rs, rt, rd, 2'b00);
						2'd1:    instr = enc_r(OPC_ARITH, rs, rt, rd, 2'b01);
						2'd2:    instr = enc_r(OPC_SLT, rs, rt, rd, 2'b00);
						default: instr = enc_r(OPC_SCO, rs, rt, rd, 2'b00);
					endcase
					pend_rd   = rd;
					pend_data = ref_result(kind[1:0], model_regs[rs], model_regs[rt]);
				end
				model_regs[pend_rd] = pend_data;
			end
		end
		end_test("random", errs);
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		pc           = '0;
		lfsr_state   = 32'h8a24;
		error_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		build_table();
		apply_reset();
		run_table();
		run_halt();
		run_random();
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: alu_exec_unit.f
+incdir+include
rtl/alu_exec_pkg.sv
rtl/alu_destination_decode.sv
rtl/alu_control_decode.sv
rtl/register_file.sv
rtl/alu.sv
rtl/data_memory.sv
rtl/writeback_stage.sv
rtl/alu_exec_unit.sv
tests/alu_exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f alu_exec_unit.f \
	--top-module alu_exec_unit_tb \
	-o sim_alu_exec_unit

./obj_dir/sim_alu_exec_unit | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
